// File: sevenSegPkg.sv
package sevenSegPkg;

    // Display geometry
    localparam int numDigits = 4;

    // APB bus
    typedef logic [11:0] apbAddr;
    typedef logic [31:0] apbData;

    // Display data, digit 0 in the lowest nibble
    typedef logic [3:0]               hexDigit;
    typedef logic [numDigits*4-1:0]   digitWord;
    typedef logic [$clog2(numDigits)-1:0] digitIdx;

    // Active low, one bit per digit
    typedef logic [numDigits-1:0] anodeVec;

    // Active low, bit 0 is segment a through bit 6 for segment g
    typedef logic [6:0] segVec;

    // Refresh divider and its counter
    typedef logic [15:0] scanCount;

    // Register map, byte offsets
    localparam apbAddr addrDigits  = 12'h000;
    localparam apbAddr addrDpMask  = 12'h004;
    localparam apbAddr addrCtrl    = 12'h008;
    localparam apbAddr addrScanDiv = 12'h00C;

    // Divider value after reset
    localparam scanCount scanDivReset = 16'h000F;

endpackage

// File: segDecoder.sv
`timescale 1ns/1ps

module segDecoder import sevenSegPkg::*; (
    input  hexDigit digit,
    input  logic    dpOn,
    output segVec   seg,
    output logic    dp
);

    // Segment patterns are listed g down to a, a zero lights the segment
    always_comb begin
        case (digit)
            4'h0: begin
                seg = 7'b100_0000;
            end
            4'h1: begin
                seg = 7'b111_1001;
            end
            4'h2: begin
                seg = 7'b010_0100;
            end
            4'h3: begin
                seg = 7'b011_0000;
            end
            4'h4: begin
                seg = 7'b001_1001;
            end
            4'h5: begin
                seg = 7'b001_0010;
            end
            4'h6: begin
                seg = 7'b000_0010;
            end
            4'h7: begin
                seg = 7'b111_1000;
            end
            4'h8: seg = 7'b000_0000;
            4'h9: seg = 7'b001_0000;
            4'hA: seg = 7'b000_1000;
            // Lower case b and d keep them apart from 8 and 0
            4'hB: seg = 7'b000_0011;
            4'hC: seg = 7'b100_0110;
            4'hD: seg = 7'b010_0001;
            4'hE: seg = 7'b000_0110;
            4'hF: seg = 7'b000_1110;
            default: begin
                seg = 7'b111_1111;
            end
        endcase
    end

    // Decimal point, also active low
    assign dp = ~dpOn;

endmodule

// File: apbDisplayRegs.sv
`timescale 1ns/1ps

module apbDisplayRegs import sevenSegPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  apbAddr               paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apbData               pwdata,
    output apbData               prdata,
    output logic                 pready,
    output logic                 pslverr,
    output digitWord             digits,
    output logic [numDigits-1:0] dpMask,
    output logic                 enable,
    output scanCount             scanDiv
);

    logic   setupPhase;
    logic   accessPhase;
    logic   addrLegal;
    apbData readMux;

    assign setupPhase  = psel && !penable;
    assign accessPhase = psel && penable;

    // No wait states
    assign pready = 1'b1;

    // Misaligned offsets fall into the default branch as well
    always_comb begin
        addrLegal = 1'b1;
        readMux   = '0;
        case (paddr)
            addrDigits: begin
                readMux = apbData'(digits);
            end
            addrDpMask: begin
                readMux = apbData'(dpMask);
            end
            addrCtrl: begin
                readMux = apbData'(enable);
            end
            addrScanDiv: begin
                readMux = apbData'(scanDiv);
            end
            default: begin
                addrLegal = 1'b0;
            end
        endcase
    end

    // Response is captured at the end of setup so it is valid during access
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setupPhase) begin
            if (addrLegal && !pwrite) begin
                prdata <= readMux;
            end else begin
                prdata <= '0;
            end
            pslverr <= !addrLegal;
        end else begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    // Register writes land on the edge that ends the access phase
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            digits  <= '0;
            dpMask  <= '0;
            enable  <= 1'b0;
            scanDiv <= scanDivReset;
        end else if (accessPhase && pwrite && addrLegal) begin
            case (paddr)
                addrDigits: begin
                    digits <= pwdata[$bits(digitWord)-1:0];
                end
                addrDpMask: begin
                    dpMask <= pwdata[numDigits-1:0];
                end
                addrCtrl: begin
                    enable <= pwdata[0];
                end
                addrScanDiv: begin
                    scanDiv <= pwdata[$bits(scanCount)-1:0];
                end
                default: begin
                    // Unreachable, addrLegal already excludes it
                    digits <= digits;
                end
            endcase
        end
    end

endmodule

// File: digitScanner.sv
`timescale 1ns/1ps

module digitScanner import sevenSegPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  digitWord             digits,
    input  logic [numDigits-1:0] dpMask,
    input  logic                 enable,
    input  scanCount             scanDiv,
    output hexDigit              curDigit,
    output logic                 curDp,
    output anodeVec              anodes
);

    scanCount count;
    digitIdx  idx;
    digitIdx  nextIdx;
    logic     running;
    logic     advance;

    // First digit after enable is always digit 0
    assign nextIdx = running ? digitIdx'(idx + 1'b1) : '0;

    // Count has run out, or scanning just started
    assign advance = !running || (count == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count    <= '0;
            idx      <= '0;
            running  <= 1'b0;
            anodes   <= '1;
            curDigit <= '0;
            curDp    <= 1'b0;
        end else if (!enable) begin
            // Dark display, rotation parked at digit 0
            count   <= scanDiv;
            idx     <= '0;
            running <= 1'b0;
            anodes  <= '1;
        end else if (advance) begin
            count    <= scanDiv;
            idx      <= nextIdx;
            running  <= 1'b1;
            anodes   <= ~(anodeVec'(1) << nextIdx);
            curDigit <= digits[nextIdx*$bits(hexDigit) +: $bits(hexDigit)];
            curDp    <= dpMask[nextIdx];
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: sevenSegDisplay.sv
`timescale 1ns/1ps

module sevenSegDisplay import sevenSegPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  apbAddr  paddr,
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  apbData  pwdata,
    output apbData  prdata,
    output logic    pready,
    output logic    pslverr,
    output anodeVec anodes,
    output segVec   seg,
    output logic    dp
);

    digitWord             digits;
    logic [numDigits-1:0] dpMask;
    logic                 enable;
    scanCount             scanDiv;
    hexDigit              curDigit;
    logic                 curDp;

    apbDisplayRegs i_apbDisplayRegs (
        .clk     (clk),
        .rstN    (rstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .digits  (digits),
        .dpMask  (dpMask),
        .enable  (enable),
        .scanDiv (scanDiv)
    );

    digitScanner i_digitScanner (
        .clk      (clk),
        .rstN     (rstN),
        .digits   (digits),
        .dpMask   (dpMask),
        .enable   (enable),
        .scanDiv  (scanDiv),
        .curDigit (curDigit),
        .curDp    (curDp),
        .anodes   (anodes)
    );

    segDecoder i_segDecoder (
        .digit (curDigit),
        .dpOn  (curDp),
        .seg   (seg),
        .dp    (dp)
    );

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low over three rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

// File: sevenSegDisplay_checker.sv
`timescale 1ns/1ps

module sevenSegDisplay_checker import sevenSegPkg::*; (
    input logic    clk,
    input logic    rstN,
    input logic    psel,
    input logic    penable,
    input logic    pready,
    input logic    pslverr,
    input logic    enable,
    input anodeVec anodes
);

    int failCount = 0;

    // At most one digit lit
    anodeOneCold: assert property (@(posedge clk) disable iff (!rstN) $onehot0(~anodes))
        else begin
            failCount++;
            $error("more than one anode low: %b", anodes);
        end

    // Scanner reacts one edge after enable drops
    darkWhenOff: assert property (@(posedge clk) disable iff (!rstN) !enable |=> (&anodes))
        else begin
            failCount++;
            $error("anodes not dark while disabled: %b", anodes);
        end

    errOnlyInAccess: assert property (@(posedge clk) disable iff (!rstN)
        pslverr |-> (psel && penable))
        else begin
            failCount++;
            $error("pslverr high outside an access phase");
        end

    readyHigh: assert property (@(posedge clk) disable iff (!rstN) pready)
        else begin
            failCount++;
            $error("pready dropped");
        end

endmodule

bind sevenSegDisplay sevenSegDisplay_checker i_checker (
    .clk     (clk),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .enable  (enable),
    .anodes  (anodes)
);

// File: tb.sv
`timescale 1ns/1ps

module tb import sevenSegPkg::*; ();

    logic    clk;
    logic    rstN;
    apbAddr  paddr;
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbData  pwdata;
    apbData  prdata;
    logic    pready;
    logic    pslverr;
    anodeVec anodes;
    segVec   seg;
    logic    dp;

    segVec                glyph [16];
    string                rowName [$];
    digitWord             rowDigits [$];
    logic [numDigits-1:0] rowMask [$];
    scanCount             rowDiv [$];
    logic [31:0]          lfsrState = 32'h92ec_9f9d;

    tbClock i_tbClock (.clk(clk), .rstN(rstN));

    sevenSegDisplay i_sevenSegDisplay (.*);

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        if (i_sevenSegDisplay.i_checker.failCount != 0) begin
            stopOnError("an assertion in the checker failed");
        end
    endtask

    task automatic checkSeg(input string name, input segVec expected, input segVec actual);
        if (actual !== expected) begin
            stopOnError($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkAnodes(input string name, input anodeVec expected, input anodeVec actual);
        if (actual !== expected) begin
            stopOnError($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkData(input string name, input apbData expected, input apbData actual);
        if (actual !== expected) begin
            stopOnError($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("error %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic checkCount(input string name, input scanCount expected, input scanCount actual);
        if (actual !== expected) begin
            stopOnError($sformatf("error %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // Setup cycle, then access cycle where the response is valid
    task automatic apbTransfer(input apbAddr addr, input logic write, input apbData wdata,
                               output apbData rdata, output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        tick();
        penable = 1'b1;
        rdata   = prdata;
        err     = pslverr;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbWrite(input string name, input apbAddr addr, input apbData data);
        apbData rdata;
        logic   err;
        apbTransfer(addr, 1'b1, data, rdata, err);
        checkBit({name, " pslverr"}, 1'b0, err);
    endtask

    task automatic apbRead(input string name, input apbAddr addr, input apbData expected);
        apbData rdata;
        logic   err;
        apbTransfer(addr, 1'b0, '0, rdata, err);
        checkBit({name, " pslverr"}, 1'b0, err);
        checkData(name, expected, rdata);
    endtask

    task automatic badAccess(input string name, input apbAddr addr, input logic write);
        apbData rdata;
        logic   err;
        apbTransfer(addr, write, 32'hFFFF_FFFF, rdata, err);
        checkBit({name, " pslverr"}, 1'b1, err);
        checkData({name, " prdata"}, '0, rdata);
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
    endtask

    task automatic waitAnodesChange(input string name, input anodeVec prev, input int limit);
        int n;
        n = 0;
        while (anodes === prev) begin
            if (n == limit) begin
                stopOnError($sformatf("timeout in %s, anodes stuck at %b", name, prev));
            end
            tick();
            n++;
        end
    endtask

    task automatic countLit(input string name, input anodeVec pattern, input int limit,
                            output int n);
        n = 0;
        while (anodes === pattern) begin
            n++;
            if (n > limit) begin
                stopOnError($sformatf("timeout in %s, digit never went dark", name));
            end
            tick();
        end
    endtask

    task automatic runRow(input int r);
        anodeVec expAnodes;
        hexDigit nibble;
        string   tag;
        int      lit;
        int      limit;
        limit = 4 * numDigits * (int'(rowDiv[r]) + 1);
        apbWrite("rowStop", addrCtrl, 32'h0);
        apbWrite("rowDigits", addrDigits, apbData'(rowDigits[r]));
        apbWrite("rowMask", addrDpMask, apbData'(rowMask[r]));
        apbWrite("rowDiv", addrScanDiv, apbData'(rowDiv[r]));
        apbWrite("rowStart", addrCtrl, 32'h1);
        expAnodes = '1;
        for (int d = 0; d < numDigits; d++) begin
            tag = $sformatf("%s digit %0d", rowName[r], d);
            waitAnodesChange(tag, expAnodes, limit);
            expAnodes    = '1;
            expAnodes[d] = 1'b0;
            checkAnodes({tag, " anodes"}, expAnodes, anodes);
            nibble = rowDigits[r][4*d +: 4];
            checkSeg({tag, " seg"}, glyph[nibble], seg);
            checkBit({tag, " dp"}, !rowMask[r][d], dp);
            countLit(tag, expAnodes, limit, lit);
            if (d == 1) begin
                checkCount({tag, " lit cycles"}, rowDiv[r] + 1'b1, scanCount'(lit));
            end
        end
        // Rotation wraps back to digit 0
        checkAnodes({rowName[r], " wrap"}, 4'b1110, anodes);
    endtask

    initial begin
        logic [31:0] bits;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;

        // Lit segments as gfedcba, inverted below to active low
        glyph = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                  7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        foreach (glyph[i]) begin
            glyph[i] = ~glyph[i];
        end
        rowName   = '{"nibbles0to3", "nibbles4to7", "nibbles8toB", "nibblesCtoF"};
        rowDigits = '{16'h3210, 16'h7654, 16'hBA98, 16'hFEDC};
        rowMask   = '{4'b0001, 4'b1010, 4'b0101, 4'b1111};
        rowDiv    = '{16'd2, 16'd0, 16'd5, 16'd1};
        for (int k = 0; k < 2; k++) begin
            rowName.push_back($sformatf("lfsrRow%0d", k));
            drawBits(16, bits);
            rowDigits.push_back(digitWord'(bits));
            drawBits(4, bits);
            rowMask.push_back(bits[3:0]);
            drawBits(3, bits);
            rowDiv.push_back(scanCount'(bits));
        end

        for (int n = 0; rstN !== 1'b1; n++) begin
            if (n == 20) begin
                stopOnError("reset was never released");
            end
            tick();
        end
        tick();

        checkAnodes("resetAnodes", '1, anodes);
        apbRead("resetDigits", addrDigits, 32'h0);
        apbRead("resetDpMask", addrDpMask, 32'h0);
        apbRead("resetCtrl", addrCtrl, 32'h0);
        apbRead("resetScanDiv", addrScanDiv, 32'h0000_000F);

        // Upper bits beyond each register width read back as zero
        apbWrite("wrDigits", addrDigits, 32'hDEAD_BEEF);
        apbRead("rdDigits", addrDigits, 32'h0000_BEEF);
        apbWrite("wrDpMask", addrDpMask, 32'hFFFF_FFF5);
        apbRead("rdDpMask", addrDpMask, 32'h0000_0005);
        apbWrite("wrCtrlOn", addrCtrl, 32'hFFFF_FFFF);
        apbRead("rdCtrlOn", addrCtrl, 32'h0000_0001);
        apbWrite("wrCtrlOff", addrCtrl, 32'hFFFF_FFFE);
        apbRead("rdCtrlOff", addrCtrl, 32'h0);
        apbWrite("wrScanDiv", addrScanDiv, 32'h1234_5678);
        apbRead("rdScanDiv", addrScanDiv, 32'h0000_5678);

        badAccess("unmappedRead", 12'h010, 1'b0);
        badAccess("unmappedWrite", 12'h010, 1'b1);
        badAccess("misalignedRead", 12'h006, 1'b0);
        badAccess("misalignedWrite", 12'h002, 1'b1);
        apbRead("keptDigits", addrDigits, 32'h0000_BEEF);
        apbRead("keptDpMask", addrDpMask, 32'h0000_0005);
        apbRead("keptCtrl", addrCtrl, 32'h0);
        apbRead("keptScanDiv", addrScanDiv, 32'h0000_5678);

        for (int r = 0; r < rowName.size(); r++) begin
            runRow(r);
        end

        apbWrite("stopAgain", addrCtrl, 32'h0);
        tick();
        checkAnodes("darkAfterStop", '1, anodes);
        apbWrite("startAgain", addrCtrl, 32'h1);
        tick();
        checkAnodes("digit0AfterStart", 4'b1110, anodes);

        if (i_sevenSegDisplay.i_checker.failCount != 0) begin
            $display("Test failed");
            $fatal(1, "assertion failures in the checker");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: all.f
sevenSegPkg.sv
segDecoder.sv
apbDisplayRegs.sv
digitScanner.sv
sevenSegDisplay.sv
tbClock.sv
sevenSegDisplay_checker.sv
tb.sv
